// File: address_controller.sv
`timescale 1ns/10ps

module address_controller
  import player_pkg::*;
#(
  parameter flash_addr_t LAST_WORD = 23'h7FFFF
) (
  input  logic        clk,
  input  logic        reset,
  input  cmd_e        cmd,
  input  logic        word_done,
  output flash_addr_t word_address,
  output play_state_e play_state
);

  play_state_e state_next;
  flash_addr_t addr_next;
  logic        playing;
  logic        backward;

  assign playing  = (play_state == play_fw) || (play_state == play_bw);
  assign backward = (play_state == idle_bw) || (play_state == play_bw);

  // ==========================================================================
  // Playback state
  // ==========================================================================
  always_comb begin
    state_next = play_state;
    case (cmd)
      cmd_play: begin
        if (play_state == idle_fw) state_next = play_fw;
        else if (play_state == idle_bw) state_next = play_bw;
      end
      cmd_pause: begin
        if (play_state == play_fw) state_next = idle_fw;
        else if (play_state == play_bw) state_next = idle_bw;
      end
      cmd_backward: state_next = playing ? play_bw : idle_bw;  // Keep run/idle
      cmd_forward:  state_next = playing ? play_fw : idle_fw;
      default: ;
    endcase
  end

  // ==========================================================================
  // Word address
  // ==========================================================================
  always_comb begin
    addr_next = word_address;
    if (cmd == cmd_restart) begin
      // Restart goes to the start of the song in the current direction
      addr_next = backward ? LAST_WORD : '0;
    end else if (word_done) begin
      if (backward) begin
        if (word_address == '0) addr_next = LAST_WORD;  // Wrap to end
        else addr_next = word_address - 1'b1;
      end else begin
        if (word_address == LAST_WORD) addr_next = '0;  // Wrap to start
        else addr_next = word_address + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      play_state   <= idle_fw;
      word_address <= '0;
    end else begin
      play_state   <= state_next;
      word_address <= addr_next;
    end
  end

endmodule

// File: command_decoder.sv
`timescale 1ns/10ps

module command_decoder
  import player_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] key_code,
  input  logic       key_valid,
  output cmd_e       cmd
);

  cmd_e cmd_next;

  // Either case of a letter maps to the same command
  always_comb begin
    cmd_next = cmd_none;
    if (key_valid) begin
      case (key_code)
        KEY_UPPER_D, KEY_LOWER_D: cmd_next = cmd_pause;
        KEY_UPPER_E, KEY_LOWER_E: cmd_next = cmd_play;
        KEY_UPPER_B, KEY_LOWER_B: cmd_next = cmd_backward;
        KEY_UPPER_F, KEY_LOWER_F: cmd_next = cmd_forward;
        KEY_UPPER_R, KEY_LOWER_R: cmd_next = cmd_restart;
        default:                  cmd_next = cmd_none;  // Unknown key ignored
      endcase
    end
  end

  // One-cycle command pulse
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmd <= cmd_none;
    end else begin
      cmd <= cmd_next;
    end
  end

endmodule

// File: flash_reader.sv
`timescale 1ns/10ps

module flash_reader
  import player_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  flash_addr_t word_address,
  input  play_state_e play_state,
  input  logic        sample_tick,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output logic        flash_read,
  output logic [3:0]  flash_byteenable,
  output sample_t     sample,
  output logic        sample_valid,
  output logic        word_done
);

  read_state_e state;
  flash_word_t word_q;
  logic        word_bw;      // Direction seen when the word arrived
  logic        playing;
  logic        play_slot;    // Tick that may release a sample
  sample_t     first_half;
  sample_t     second_half;

  assign playing   = (play_state == play_fw) || (play_state == play_bw);
  assign play_slot = sample_tick && playing;

  // Address comes straight from the controller and holds during the request
  assign flash_read       = (state == rd_request);
  assign flash_byteenable = flash_read ? 4'hF : 4'h0;

  assign first_half  = word_bw ? word_q[31:16] : word_q[15:0];
  assign second_half = word_bw ? word_q[15:0]  : word_q[31:16];

  // ==========================================================================
  // Fetch and output sequencer
  // ==========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= rd_start;
      sample_valid <= 1'b0;
      word_done    <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      word_done    <= 1'b0;
      case (state)
        rd_start:   if (playing) state <= rd_request;
        rd_request: if (!flash_waitrequest) state <= rd_wait;  // Request accepted
        rd_wait:    if (flash_readdatavalid) state <= rd_first;
        rd_first: begin
          if (play_slot) begin
            sample_valid <= 1'b1;
            state        <= rd_second;
          end
        end
        rd_second: begin
          if (play_slot) begin
            sample_valid <= 1'b1;
            word_done    <= 1'b1;  // Controller steps the address
            state        <= rd_start;
          end
        end
        default: state <= rd_start;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (state == rd_wait && flash_readdatavalid) begin
      word_q  <= flash_readdata;
      word_bw <= (play_state == play_bw) || (play_state == idle_bw);
    end
    if (play_slot && state == rd_first) sample <= first_half;
    else if (play_slot && state == rd_second) sample <= second_half;
  end

endmodule

// File: player_pkg.sv
package player_pkg;

  // ==========================================================================
  // Data widths
  // ==========================================================================
  typedef logic [22:0]        flash_addr_t;  // One flash word per address
  typedef logic [31:0]        flash_word_t;  // Two samples per word
  typedef logic signed [15:0] sample_t;
  typedef logic [31:0]        rate_t;        // Hz

  // ==========================================================================
  // Encodings
  // ==========================================================================
  typedef enum logic [2:0] {
    cmd_none,
    cmd_pause,
    cmd_play,
    cmd_backward,
    cmd_forward,
    cmd_restart
  } cmd_e;

  // Bit 1 set means playing, bit 0 set means backward
  typedef enum logic [1:0] {
    idle_fw = 2'b00,
    idle_bw = 2'b01,
    play_fw = 2'b10,
    play_bw = 2'b11
  } play_state_e;

  typedef enum logic [2:0] {
    rd_start,
    rd_request,
    rd_wait,
    rd_first,
    rd_second
  } read_state_e;

  // Command keys, ASCII
  localparam logic [7:0] KEY_UPPER_D = 8'h44;  // Pause
  localparam logic [7:0] KEY_UPPER_E = 8'h45;  // Play
  localparam logic [7:0] KEY_UPPER_B = 8'h42;  // Backward
  localparam logic [7:0] KEY_UPPER_F = 8'h46;  // Forward
  localparam logic [7:0] KEY_UPPER_R = 8'h52;  // Restart
  localparam logic [7:0] KEY_LOWER_D = 8'h64;
  localparam logic [7:0] KEY_LOWER_E = 8'h65;
  localparam logic [7:0] KEY_LOWER_B = 8'h62;
  localparam logic [7:0] KEY_LOWER_F = 8'h66;
  localparam logic [7:0] KEY_LOWER_R = 8'h72;

endpackage

// File: sample_rate_gen.sv
`timescale 1ns/10ps

module sample_rate_gen
  import player_pkg::*;
#(
  parameter rate_t CLK_HZ       = 50_000_000,
  parameter rate_t BASE_RATE_HZ = 22_000,
  parameter rate_t RATE_STEP_HZ = 1_000
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  speed_up,
  input  logic  speed_down,
  input  logic  speed_reset,
  output rate_t rate_hz,
  output logic  sample_tick
);

  localparam rate_t MAX_RATE_HZ = 2 * BASE_RATE_HZ;
  localparam rate_t BASE_PERIOD = CLK_HZ / BASE_RATE_HZ;

  rate_t rate_next;
  rate_t period;       // Clock cycles per sample
  rate_t cycle_count;
  logic  speed_event;

  assign speed_event = speed_up | speed_down | speed_reset;

  // ==========================================================================
  // Rate stepping with clamping
  // ==========================================================================
  always_comb begin
    rate_next = rate_hz;
    if (speed_reset) begin
      rate_next = BASE_RATE_HZ;
    end else if (speed_up) begin
      if (rate_hz + RATE_STEP_HZ > MAX_RATE_HZ) rate_next = MAX_RATE_HZ;
      else rate_next = rate_hz + RATE_STEP_HZ;
    end else if (speed_down) begin
      if (rate_hz < 2 * RATE_STEP_HZ) rate_next = RATE_STEP_HZ;  // Floor at one step
      else rate_next = rate_hz - RATE_STEP_HZ;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rate_hz <= BASE_RATE_HZ;
      period  <= BASE_PERIOD;
    end else if (speed_event) begin
      rate_hz <= rate_next;
      period  <= CLK_HZ / rate_next;  // Never zero, rate is clamped
    end
  end

  // ==========================================================================
  // Tick divider
  // ==========================================================================
  assign sample_tick = (cycle_count == period - 1'b1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cycle_count <= '0;
    end else if (speed_event || sample_tick) begin
      cycle_count <= '0;  // New rate starts a fresh period
    end else begin
      cycle_count <= cycle_count + 1'b1;
    end
  end

endmodule

// File: song_player.sv
`timescale 1ns/10ps

module song_player
  import player_pkg::*;
#(
  parameter rate_t       CLK_HZ       = 50_000_000,
  parameter rate_t       BASE_RATE_HZ = 22_000,
  parameter rate_t       RATE_STEP_HZ = 1_000,
  parameter flash_addr_t LAST_WORD    = 23'h7FFFF
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  key_code,
  input  logic        key_valid,
  input  logic        speed_up,
  input  logic        speed_down,
  input  logic        speed_reset,
  // Flash read port
  output logic        flash_read,
  output flash_addr_t flash_address,
  output logic [3:0]  flash_byteenable,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  // Playback outputs
  output sample_t     sample,
  output logic        sample_valid,
  output play_state_e play_state,
  output rate_t       rate_hz
);

  cmd_e cmd;
  logic word_done;
  logic sample_tick;

  command_decoder u_command_decoder (
    .clk       (clk),
    .reset     (reset),
    .key_code  (key_code),
    .key_valid (key_valid),
    .cmd       (cmd)
  );

  sample_rate_gen #(
    .CLK_HZ       (CLK_HZ),
    .BASE_RATE_HZ (BASE_RATE_HZ),
    .RATE_STEP_HZ (RATE_STEP_HZ)
  ) u_sample_rate_gen (
    .clk         (clk),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .rate_hz     (rate_hz),
    .sample_tick (sample_tick)
  );

  address_controller #(
    .LAST_WORD (LAST_WORD)
  ) u_address_controller (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .word_done    (word_done),
    .word_address (flash_address),  // Word address goes straight to the flash
    .play_state   (play_state)
  );

  flash_reader u_flash_reader (
    .clk                 (clk),
    .reset               (reset),
    .word_address        (flash_address),
    .play_state          (play_state),
    .sample_tick         (sample_tick),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_byteenable    (flash_byteenable),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .word_done           (word_done)
  );

endmodule

// File: tb.f
player_pkg.sv
command_decoder.sv
sample_rate_gen.sv
address_controller.sv
flash_reader.sv
song_player.sv
tb_clock_gen.sv
tb_flash_model.sv
tb_song_player.sv

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lands just after an edge, like the other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

// File: tb_flash_model.sv
`timescale 1ns/10ps

module tb_flash_model
  import player_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        read,
  input  flash_addr_t address,
  output logic        waitrequest,
  output flash_word_t readdata,
  output logic        readdatavalid
);

  integer      seed;
  logic [1:0]  wait_left;  // Stall cycles before the next accept
  logic [1:0]  latency;    // Cycles until the data returns
  flash_addr_t addr_q;

  initial seed = 32'he547f4cc;

  assign waitrequest = (wait_left != 2'd0);

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      wait_left     <= 2'd0;
      latency       <= 2'd0;
      addr_q        <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end else begin
      readdatavalid <= 1'b0;
      if (read && wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else if (read) begin
        addr_q    <= address;  // Request accepted
        latency   <= 2'd2;
        wait_left <= {$random(seed)} % 3;
      end else if (latency != 2'd0) begin
        latency <= latency - 2'd1;
      end
      if (latency == 2'd1) begin
        readdatavalid <= 1'b1;
        readdata      <= {addr_q[14:0], 1'b1, addr_q[14:0], 1'b0};  // Upper 2a+1, lower 2a
      end
    end
  end

endmodule

// File: tb_song_player.sv
`timescale 1ns/10ps

module tb_song_player
  import player_pkg::*;
();

  localparam rate_t       CLK_HZ       = 1_000_000;
  localparam rate_t       BASE_RATE_HZ = 50_000;
  localparam rate_t       RATE_STEP_HZ = 10_000;
  localparam flash_addr_t LAST_WORD    = 7;
  localparam int NUM_SAMPLES  = 2 * (LAST_WORD + 1);
  localparam int NUM_ROWS     = 17;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 100;  // Watch window of a row that expects silence
  localparam int ROW_MARGIN   = 50;
  localparam int EV_NONE = 0, EV_KEY = 1, EV_UP = 2, EV_DOWN = 3, EV_RESET = 4;

  logic clk, reset, key_valid, speed_up, speed_down, speed_reset;
  logic [7:0]  key_code;
  logic        flash_read, flash_waitrequest, flash_readdatavalid, sample_valid;
  flash_addr_t flash_address;
  logic [3:0]  flash_byteenable;
  flash_word_t flash_readdata;
  sample_t     sample;
  sample_t     next_value = '0;  // Forward play opens with sample 0
  play_state_e play_state;
  rate_t       rate_hz, exp_period;

  // Stimulus table, one row per step
  int          row_event [NUM_ROWS];
  logic [7:0]  row_key   [NUM_ROWS];
  play_state_e row_state [NUM_ROWS];
  rate_t       row_rate  [NUM_ROWS];
  int          row_count [NUM_ROWS];
  string       row_name  [NUM_ROWS];

  int error_count = 0, check_count = 0, row_errors, row_samples, row_cycles;
  int tb_cycles = 0, watch_cycles = 0, cycle_limit = 0, last_sample_cycle, samples_total = 0;
  int skip_left = 0, restart_value = -1;
  int read_grace;
  bit quiet, exp_bw = 0, anchored = 1;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk(clk), .reset(reset));

  song_player #(
    .CLK_HZ(CLK_HZ), .BASE_RATE_HZ(BASE_RATE_HZ),
    .RATE_STEP_HZ(RATE_STEP_HZ), .LAST_WORD(LAST_WORD)
  ) UUT (
    .clk(clk), .reset(reset), .key_code(key_code), .key_valid(key_valid),
    .speed_up(speed_up), .speed_down(speed_down), .speed_reset(speed_reset),
    .flash_read(flash_read), .flash_address(flash_address),
    .flash_byteenable(flash_byteenable), .flash_waitrequest(flash_waitrequest),
    .flash_readdata(flash_readdata), .flash_readdatavalid(flash_readdatavalid),
    .sample(sample), .sample_valid(sample_valid), .play_state(play_state), .rate_hz(rate_hz)
  );

  tb_flash_model u_flash (
    .clk(clk), .reset(reset), .read(flash_read), .address(flash_address),
    .waitrequest(flash_waitrequest), .readdata(flash_readdata),
    .readdatavalid(flash_readdatavalid)
  );

  // ==========================================================================
  // Compare tasks
  // ==========================================================================
  task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      error_count++;
      row_errors++;
    end
  endtask

  task automatic check_state(input play_state_e got, input play_state_e exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("error at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
      error_count++;
      row_errors++;
    end
  endtask

  task automatic check_rate(input rate_t got, input rate_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      error_count++;
      row_errors++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("Problem at %0t ns: %s", $time, what);
    error_count++;
    row_errors++;
  endtask

  // ==========================================================================
  // Reference model and per-cycle monitor
  // ==========================================================================
  function automatic bit is_backward(input play_state_e st);
    return (st == idle_bw) || (st == play_bw);
  endfunction

  task automatic model_sample(input sample_t got);
    int g;
    g = got;
    if (skip_left > 0) begin
      skip_left--;  // Samples still from the word in flight
    end else if (!anchored) begin
      if (restart_value >= 0) check_sample(got, sample_t'(restart_value), "sample after restart");
      anchored = 1'b1;
    end else begin
      check_sample(got, next_value, "sample");
    end
    next_value = exp_bw ? (g + NUM_SAMPLES - 1) % NUM_SAMPLES : (g + 1) % NUM_SAMPLES;
  endtask

  task automatic next_cycle();
    rate_t gap;
    @(posedge clk);
    #2;
    tb_cycles++;
    row_cycles++;
    if (flash_read && flash_byteenable != 4'hF) report_problem("byteenable not all ones");
    if (quiet && row_cycles > read_grace && flash_read) report_problem("flash read while idle");
    if (sample_valid) begin
      if (quiet) begin
        report_problem("sample_valid while idle");
      end else begin
        gap = tb_cycles - last_sample_cycle;
        if (last_sample_cycle >= 0) check_rate(gap, exp_period, "sample gap");
        last_sample_cycle = tb_cycles;
        model_sample(sample);
        row_samples++;
        samples_total++;
      end
    end
  endtask

  task automatic apply_event(input int idx);
    case (row_event[idx])
      EV_KEY: begin
        key_code  = row_key[idx];
        key_valid = 1'b1;
      end
      EV_UP:    speed_up = 1'b1;
      EV_DOWN:  speed_down = 1'b1;
      EV_RESET: speed_reset = 1'b1;
      default: ;
    endcase
    next_cycle();
    key_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  task automatic set_row(input int idx, input int ev, input logic [7:0] key,
                         input play_state_e st, input rate_t rate, input int n, input string name);
    row_event[idx] = ev;
    row_key[idx]   = key;
    row_state[idx] = st;
    row_rate[idx]  = rate;
    row_count[idx] = n;
    row_name[idx]  = name;
  endtask

  task automatic load_table();
    set_row(0,  EV_NONE,  8'h00,       idle_fw, 50_000,  0,  "after reset");
    set_row(1,  EV_KEY,   KEY_LOWER_E, play_fw, 50_000,  20, "play forward");
    set_row(2,  EV_KEY,   KEY_UPPER_B, play_bw, 50_000,  12, "play backward");
    set_row(3,  EV_KEY,   KEY_LOWER_R, play_bw, 50_000,  8,  "restart backward");
    set_row(4,  EV_KEY,   KEY_LOWER_D, idle_bw, 50_000,  0,  "pause");
    set_row(5,  EV_KEY,   KEY_UPPER_F, idle_fw, 50_000,  0,  "forward while idle");
    set_row(6,  EV_KEY,   8'h78,       idle_fw, 50_000,  0,  "unknown key");
    set_row(7,  EV_KEY,   KEY_UPPER_E, play_fw, 50_000,  8,  "resume forward");
    set_row(8,  EV_UP,    8'h00,       play_fw, 60_000,  6,  "speed up");
    set_row(9,  EV_UP,    8'h00,       play_fw, 70_000,  6,  "speed up");
    set_row(10, EV_DOWN,  8'h00,       play_fw, 60_000,  6,  "speed down");
    set_row(11, EV_UP,    8'h00,       play_fw, 70_000,  4,  "speed up");
    set_row(12, EV_UP,    8'h00,       play_fw, 80_000,  4,  "speed up");
    set_row(13, EV_UP,    8'h00,       play_fw, 90_000,  4,  "speed up");
    set_row(14, EV_UP,    8'h00,       play_fw, 100_000, 4,  "speed up");
    set_row(15, EV_UP,    8'h00,       play_fw, 100_000, 6,  "speed clamp");
    set_row(16, EV_RESET, 8'h00,       play_fw, 50_000,  6,  "speed reset");
  endtask

  // Longest period times the samples, plus slack per row
  function automatic int run_cycle_limit();
    int    total;
    rate_t min_rate;
    total    = RESET_CYCLES;
    min_rate = row_rate[0];
    for (int i = 1; i < NUM_ROWS; i++) if (row_rate[i] < min_rate) min_rate = row_rate[i];
    for (int i = 0; i < NUM_ROWS; i++) begin
      total += row_count[i] * (CLK_HZ / min_rate) + ROW_MARGIN;
      if (row_count[i] == 0) total += IDLE_CYCLES;
    end
    return total;
  endfunction

  // ==========================================================================
  // Watchdog and main sequence
  // ==========================================================================
  initial begin
    wait (cycle_limit != 0);
    while (watch_cycles < cycle_limit) begin
      @(posedge clk);
      watch_cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    key_code    = 8'h00;
    key_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    load_table();
    cycle_limit = run_cycle_limit();
    @(negedge reset);
    for (int i = 0; i < NUM_ROWS; i++) begin
      row_errors        = 0;
      row_samples       = 0;
      row_cycles        = 0;
      last_sample_cycle = -1;
      quiet             = (row_count[i] == 0);
      read_grace        = (i == 0) ? 0 : 10;  // A fetch in flight may finish after pause
      exp_period        = CLK_HZ / row_rate[i];
      if (row_event[i] == EV_KEY && (row_key[i] == KEY_LOWER_R || row_key[i] == KEY_UPPER_R)) begin
        skip_left     = 2;
        anchored      = 1'b0;
        restart_value = (samples_total % 2 != 0) ? -1 : (exp_bw ? NUM_SAMPLES - 3 : 2);
      end else if (is_backward(row_state[i]) != exp_bw) begin
        skip_left     = 2;  // Direction change, resync on the third sample
        anchored      = 1'b0;
        restart_value = -1;
      end
      exp_bw = is_backward(row_state[i]);
      apply_event(i);
      if (quiet) begin
        while (row_cycles < IDLE_CYCLES) next_cycle();
      end else begin
        while (row_samples < row_count[i]) next_cycle();
      end
      check_state(play_state, row_state[i], "play_state");
      check_rate(rate_hz, row_rate[i], "rate_hz");
      $display("row %0d %s: state %s, rate %0d, %0d samples, %s", i, row_name[i],
               play_state.name(), rate_hz, row_samples, (row_errors == 0) ? "ok" : "FAILED");
    end
    $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
